// File: branchPredecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetchUnit_config.svh"

module branchPredecoder (
    input  wire [`ADDR_W-1:0] pc,
    input  wire [`DATA_W-1:0] instr,
    output fetchPkg::predecodeT decoded
);
    localparam logic [`ADDR_W-1:0] One = 1;

    logic [3:0]         opcode;
    logic [3:0]         minorOp;
    logic [7:0]         imm;
    logic [`ADDR_W-1:0] immExt;
    logic [`ADDR_W-1:0] branchTarget;
    logic [`ADDR_W-1:0] jumpOffset;

    assign opcode  = instr[15:12];
    assign minorOp = instr[3:0];
    assign imm     = instr[7:0];

    // Relative to the word after the branch
    assign immExt       = {{(`ADDR_W - 8){imm[7]}}, imm};
    assign branchTarget = pc + One + immExt;

    // Minor opcode times eight, operand A added at resolve
    assign jumpOffset = {{(`ADDR_W - 7){1'b0}}, minorOp, 3'b000};

    always_comb begin
        decoded = '0;
        case (opcode)
            `OP_BEQZ: begin
                decoded.isBranch     = 1'b1;
                decoded.predictTaken = imm[7];  // Backward taken, forward not
                decoded.takenTarget  = branchTarget;
            end
            `OP_JR: begin
                decoded.isJump      = 1'b1;
                decoded.takenTarget = jumpOffset;
            end
            default: begin
                decoded.takenTarget = pc + One;  // Plain fall-through
            end
        endcase
    end

endmodule

`default_nettype wire

// File: fetchPkg.sv
`default_nettype none

`include "fetchUnit_config.svh"

package fetchPkg;

    // Word handed to the execute stage
    typedef struct packed {
        logic [`ADDR_W-1:0] pc;
        logic [`DATA_W-1:0] instr;
        logic               predictedTaken;
    } fetchPacketT;

    // Predecode of one fetched word
    typedef struct packed {
        logic               isBranch;
        logic               isJump;
        logic               predictTaken;
        logic [`ADDR_W-1:0] takenTarget;  // JR carries its scaled offset here
    } predecodeT;

    // Branch or jump outcome from execute
    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] operandA;
    } resolveT;

    typedef struct packed {
        logic               valid;
        logic               mispredict;
        logic [`ADDR_W-1:0] linkAddress;
    } resolveResultT;

    // AXI4-Lite read address channel payload
    typedef struct packed {
        logic [`ADDR_W-1:0] araddr;
        logic [2:0]         arprot;
    } axiArT;

    // AXI4-Lite read data channel payload
    typedef struct packed {
        logic [`DATA_W-1:0] rdata;
        logic [1:0]         rresp;
    } axiRT;

endpackage

`default_nettype wire

// File: fetchTop.f
+incdir+.
fetchPkg.sv
branchPredecoder.sv
programCounter.sv
instrFetchPort.sv
fetchTop.sv
tbFetchTop.sv

// File: fetchTop.sv
`timescale 1ns/1ps
`default_nettype none

module fetchTop (
    input  wire                           clk,
    input  wire                           rstN,
    output wire                           arValid,
    input  wire                           arReady,
    output wire fetchPkg::axiArT          ar,
    input  wire                           rValid,
    output wire                           rReady,
    input  wire fetchPkg::axiRT           r,
    output wire fetchPkg::fetchPacketT    pkt,
    output wire                           pktValid,
    input  wire                           pktReady,
    input  wire fetchPkg::resolveT        resolve,
    output wire fetchPkg::resolveResultT  resolveResult
);
    wire                      rspValid;
    wire [15:0]               rspData;
    wire fetchPkg::predecodeT decoded;
    wire                      rspKeep;
    wire [15:0]               fetchPc;
    wire                      fetchHold;
    wire                      squash;
    wire                      predictedTaken;

    instrFetchPort port (
        .clk            (clk),
        .rstN           (rstN),
        .fetchPc        (fetchPc),
        .fetchHold      (fetchHold),
        .squash         (squash),
        .rspKeep        (rspKeep),
        .arValid        (arValid),
        .arReady        (arReady),
        .ar             (ar),
        .rValid         (rValid),
        .rReady         (rReady),
        .r              (r),
        .rspValid       (rspValid),
        .rspData        (rspData),
        .predictedTaken (predictedTaken),
        .pkt            (pkt),
        .pktValid       (pktValid),
        .pktReady       (pktReady)
    );

    // Word address is the held PC
    branchPredecoder predecoder (
        .pc      (fetchPc),
        .instr   (rspData),
        .decoded (decoded)
    );

    programCounter pcUnit (
        .clk            (clk),
        .rstN           (rstN),
        .rspValid       (rspValid),
        .decoded        (decoded),
        .resolve        (resolve),
        .rspKeep        (rspKeep),
        .fetchPc        (fetchPc),
        .fetchHold      (fetchHold),
        .squash         (squash),
        .predictedTaken (predictedTaken),
        .resolveResult  (resolveResult)
    );

endmodule

`default_nettype wire

// File: fetchUnit_config.svh
`ifndef FETCHUNIT_CONFIG_SVH
`define FETCHUNIT_CONFIG_SVH

// Instruction address and word widths
`define ADDR_W 16
`define DATA_W 16

// Major opcodes in instr[15:12]
`define OP_BEQZ 4'hC  // Relative branch if operand is zero
`define OP_JR   4'hD  // Register jump, minor opcode scales the offset

`endif

// File: instrFetchPort.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetchPort (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire [15:0]           fetchPc,
    input  wire                  fetchHold,
    input  wire                  squash,
    input  wire                  rspKeep,
    output logic                 arValid,
    input  wire                  arReady,
    output fetchPkg::axiArT      ar,
    input  wire                  rValid,
    output logic                 rReady,
    input  wire fetchPkg::axiRT  r,
    output logic                 rspValid,
    output logic [15:0]          rspData,
    input  wire                  predictedTaken,
    output fetchPkg::fetchPacketT pkt,
    output logic                 pktValid,
    input  wire                  pktReady
);
    localparam logic [2:0] ArProtInstr = 3'b100;  // Unprivileged, secure, instruction

    typedef enum logic [1:0] {
        Idle,
        AddrPhase,
        DataPhase
    } stateT;

    stateT       state;
    logic        drop;      // Response belongs to squashed path
    logic        slotFree;
    logic        issue;
    logic [15:0] araddrQ;

    // Slot is empty or drains this cycle, so the response will land
    assign slotFree = !pktValid || pktReady;
    assign issue    = (state == Idle) && !fetchHold && !squash && slotFree;

    assign arValid   = state == AddrPhase;
    assign ar.araddr = araddrQ;
    assign ar.arprot = ArProtInstr;
    assign rReady    = 1'b1;

    assign rspValid = (state == DataPhase) && rValid && !drop;
    assign rspData  = r.rdata;  // rresp not checked

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= Idle;
            drop  <= 1'b0;
        end else begin
            case (state)
                Idle:      if (issue) state <= AddrPhase;
                AddrPhase: if (arReady) state <= DataPhase;
                DataPhase: if (rValid) state <= Idle;
                default:   state <= Idle;
            endcase

            if (state == DataPhase && rValid) begin
                drop <= 1'b0;
            end else if (squash && state != Idle) begin
                drop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            araddrQ <= fetchPc;
        end
    end

    // Packet slot
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pktValid <= 1'b0;
        end else if (squash) begin
            pktValid <= 1'b0;
        end else if (rspKeep) begin
            pktValid <= 1'b1;
        end else if (pktReady) begin
            pktValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rspKeep) begin
            pkt.pc             <= fetchPc;  // PC holds while its read is out
            pkt.instr          <= rspData;
            pkt.predictedTaken <= predictedTaken;
        end
    end

endmodule

`default_nettype wire

// File: programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire                     rspValid,
    input  wire fetchPkg::predecodeT decoded,
    input  wire fetchPkg::resolveT  resolve,
    output logic                    rspKeep,
    output logic [15:0]             fetchPc,
    output logic                    fetchHold,
    output logic                    squash,
    output logic                    predictedTaken,
    output fetchPkg::resolveResultT resolveResult
);
    logic [15:0] pc;
    logic        speculating;
    logic        pendingJump;
    logic        blocked;        // Control word refused while speculating

    // Checkpoint of the branch or jump in flight
    logic        ckptPredTaken;
    logic [15:0] rollback;       // Branch address plus one
    logic [15:0] ckptTarget;
    logic [3:0]  savedMinor;

    logic        controlWord;
    logic        resolveBranch;
    logic        resolveJump;
    logic        actualTaken;
    logic        mispredict;
    logic [15:0] correctTarget;
    logic [15:0] jumpTarget;
    logic [15:0] pcInc;
    logic [15:0] nextPc;

    logic        resultValid;
    logic        resultMispredict;
    logic [15:0] resultLink;

    assign controlWord   = decoded.isBranch || decoded.isJump;
    assign resolveBranch = resolve.valid && speculating;
    assign resolveJump   = resolve.valid && pendingJump;

    // BEQZ is taken when operand A is zero
    assign actualTaken   = resolve.operandA == 16'd0;
    assign mispredict    = resolveBranch && (actualTaken != ckptPredTaken);
    assign correctTarget = actualTaken ? ckptTarget : rollback;

    assign savedMinor = ckptTarget[6:3];
    assign jumpTarget = resolve.operandA + {9'd0, savedMinor, 3'b000};

    assign squash = mispredict || resolveJump;

    // A second branch or jump waits for the current one to resolve
    assign rspKeep   = rspValid && !squash && !(speculating && controlWord);
    assign fetchHold = pendingJump || blocked;
    assign fetchPc   = pc;

    assign predictedTaken = decoded.isBranch && decoded.predictTaken;
    assign pcInc          = pc + 16'd1;

    always_comb begin
        nextPc = pc;
        if (mispredict) begin
            nextPc = correctTarget;
        end else if (resolveJump) begin
            nextPc = jumpTarget;
        end else if (rspKeep) begin
            if (decoded.isBranch) begin
                nextPc = decoded.predictTaken ? decoded.takenTarget : pcInc;
            end else if (!decoded.isJump) begin
                nextPc = pcInc;
            end
            // Jump keeps the PC until its target is known
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc          <= 16'd0;
            speculating <= 1'b0;
            pendingJump <= 1'b0;
            blocked     <= 1'b0;
        end else begin
            pc <= nextPc;

            if (resolveBranch) begin
                speculating <= 1'b0;
            end else if (rspKeep && decoded.isBranch) begin
                speculating <= 1'b1;
            end

            if (resolveJump) begin
                pendingJump <= 1'b0;
            end else if (rspKeep && decoded.isJump) begin
                pendingJump <= 1'b1;
            end

            // Refused word is refetched from the held PC
            if (resolve.valid) begin
                blocked <= 1'b0;
            end else if (rspValid && speculating && controlWord) begin
                blocked <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rspKeep && controlWord) begin
            ckptPredTaken <= predictedTaken;
            rollback      <= pcInc;
            ckptTarget    <= decoded.takenTarget;
        end
    end

    // Result goes back one cycle after the resolve pulse
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= resolve.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (resolve.valid) begin
            resultMispredict <= mispredict;
            resultLink       <= rollback;
        end
    end

    assign resolveResult.valid       = resultValid;
    assign resolveResult.mispredict  = resultMispredict;
    assign resolveResult.linkAddress = resultLink;

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module tbFetchTop -f fetchTop.f &&
    ./obj_dir/VtbFetchTop ||
    { echo "simulation failed"; exit 1; }

// File: tbFetchTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetchUnit_config.svh"

module tbFetchTop;
    logic                    clk;
    logic                    rstN;
    logic                    arValid;
    logic                    arReady;
    fetchPkg::axiArT         ar;
    logic                    rValid;
    logic                    rReady;
    fetchPkg::axiRT          r;
    fetchPkg::fetchPacketT   pkt;
    logic                    pktValid;
    logic                    pktReady;
    fetchPkg::resolveT       resolve;
    fetchPkg::resolveResultT resolveResult;

    logic [`DATA_W-1:0] image [0:255];  // Instruction memory wrapping at 256
    logic [31:0]        mainRng;
    logic [31:0]        memRng;
    logic [`ADDR_W-1:0] archPc;         // Execute-side architectural PC
    int unsigned        pktCount;

    // Previous-cycle view for the stall and AXI checks
    int                    outstanding;
    logic                  lastArValid;
    logic                  lastSlotFree;
    logic                  lastPktValid;
    logic                  lastPktReady;
    logic                  lastResolveValid;
    fetchPkg::fetchPacketT lastPkt;

    fetchTop dut (
        .clk           (clk),
        .rstN          (rstN),
        .arValid       (arValid),
        .arReady       (arReady),
        .ar            (ar),
        .rValid        (rValid),
        .rReady        (rReady),
        .r             (r),
        .pkt           (pkt),
        .pktValid      (pktValid),
        .pktReady      (pktReady),
        .resolve       (resolve),
        .resolveResult (resolveResult)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic reportMismatch(input string msg);
        abortRun($sformatf("error at %0t ns: %s", $time, msg));
    endtask

    // About a quarter BEQZ or JR and no other word uses those opcodes
    task automatic fillImage();
        logic [3:0] op;
        logic [7:0] idx;
        int         i;
        for (i = 0; i < 256; i++) begin
            idx     = i[7:0];
            mainRng = xorshift32(mainRng);
            if (mainRng[1:0] == 2'b00) begin
                if (mainRng[2]) begin
                    image[idx] = {`OP_BEQZ, mainRng[11:8], mainRng[23:16]};
                end else begin
                    image[idx] = {`OP_JR, mainRng[15:8], mainRng[19:16]};
                end
            end else begin
                op = mainRng[7:4];
                if (op == `OP_BEQZ || op == `OP_JR) begin
                    op = op ^ 4'h8;
                end
                image[idx] = {op, mainRng[27:16]};
            end
        end
    endtask

    task automatic checkIdleOutputs(input string phase);
        assert (!arValid) else reportMismatch($sformatf("arValid high %s", phase));
        assert (!pktValid) else reportMismatch($sformatf("pktValid high %s", phase));
        assert (!resolveResult.valid)
            else reportMismatch($sformatf("resolveResult.valid high %s", phase));
    endtask

    task automatic checkPacket(input fetchPkg::fetchPacketT p);
        logic [`DATA_W-1:0] word;
        logic               expPred;
        word    = image[p.pc[7:0]];
        expPred = (word[15:12] == `OP_BEQZ) && word[7];  // Backward branch predicted taken
        assert (p.pc == archPc)
            else reportMismatch($sformatf("packet pc %h, expected %h", p.pc, archPc));
        assert (p.instr == word)
            else reportMismatch($sformatf("packet instr %h at %h, expected %h",
                                          p.instr, p.pc, word));
        assert (p.predictedTaken == expPred)
            else reportMismatch($sformatf("predictedTaken %b at %h, expected %b",
                                          p.predictedTaken, p.pc, expPred));
        if (word[15:12] != `OP_BEQZ && word[15:12] != `OP_JR) begin
            archPc = archPc + 16'd1;
        end
    endtask

    // Resolves a just accepted branch or jump after a random gap
    task automatic resolveControl(input fetchPkg::fetchPacketT p);
        logic [`DATA_W-1:0] opA;
        logic [`ADDR_W-1:0] link;
        logic               taken;
        logic               expMis;
        int unsigned        delay;
        int unsigned        i;
        @(posedge clk);  // Handshake edge
        #1;
        pktReady = 1'b0;
        mainRng  = xorshift32(mainRng);
        delay    = mainRng % 5;
        opA      = mainRng[8] ? 16'd0 : mainRng[31:16];
        for (i = 0; i < delay; i++) begin
            @(posedge clk);
            #1;
        end
        resolve.valid    = 1'b1;
        resolve.operandA = opA;
        link             = p.pc + 16'd1;
        if (p.instr[15:12] == `OP_BEQZ) begin
            taken  = opA == 16'd0;
            expMis = taken != p.instr[7];
            archPc = taken ? link + {{8{p.instr[7]}}, p.instr[7:0]} : link;
        end else begin
            expMis = 1'b0;
            archPc = opA + {9'd0, p.instr[3:0], 3'b000};
        end
        @(posedge clk);
        #1;
        resolve = '0;
        assert (resolveResult.valid) else reportMismatch("no resolve result after resolve");
        assert (resolveResult.linkAddress == link)
            else reportMismatch($sformatf("linkAddress %h, expected %h",
                                          resolveResult.linkAddress, link));
        assert (resolveResult.mispredict == expMis)
            else reportMismatch($sformatf("mispredict %b at %h, expected %b",
                                          resolveResult.mispredict, p.pc, expMis));
    endtask

    initial begin
        int unsigned           idle;
        int                    i;
        fetchPkg::fetchPacketT got;
        clk      = 1'b0;
        rstN     = 1'b0;
        arReady  = 1'b0;
        rValid   = 1'b0;
        r        = '0;
        pktReady = 1'b0;
        resolve  = '0;
        mainRng  = 32'd39;
        fillImage();
        memRng = xorshift32(mainRng ^ 32'h0000_ff00);
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            checkIdleOutputs("during reset");
        end
        rstN = 1'b1;
        #1;
        checkIdleOutputs("right after reset");
        archPc   = 16'd0;
        pktCount = 0;
        idle     = 0;
        while (pktCount < 400) begin
            @(posedge clk);
            #1;
            mainRng  = xorshift32(mainRng);
            pktReady = mainRng[1:0] != 2'b00;
            if (pktValid && pktReady) begin
                got  = pkt;
                idle = 0;
                checkPacket(got);
                pktCount++;
                if (got.instr[15:12] == `OP_BEQZ || got.instr[15:12] == `OP_JR) begin
                    resolveControl(got);
                end
            end else begin
                idle++;
                assert (idle < 200) else abortRun("timeout: no packet accepted for 200 cycles");
            end
        end
        $display("Test completed successfully");
        $finish;
    end

    // AXI memory serving one read at a time with 0 to 3 cycle gaps
    initial begin
        int unsigned        waitCount;
        int unsigned        delay;
        int unsigned        i;
        logic [`ADDR_W-1:0] addr;
        logic               firstAr;
        firstAr = 1'b1;
        forever begin
            waitCount = 0;
            @(posedge clk);
            #1;
            while (!(rstN && arValid)) begin
                waitCount++;
                assert (waitCount < 1000) else abortRun("timeout: no read address for 1000 cycles");
                @(posedge clk);
                #1;
            end
            addr = ar.araddr;
            if (firstAr) begin
                assert (addr == 16'd0)
                    else reportMismatch($sformatf("first read address %h, expected 0000", addr));
                firstAr = 1'b0;
            end
            // AXI marks an instruction fetch with arprot bit 2
            assert (ar.arprot[2])
                else reportMismatch($sformatf("arprot %b does not mark an instruction fetch",
                                              ar.arprot));
            memRng = xorshift32(memRng);
            delay  = memRng % 4;
            for (i = 0; i < delay; i++) begin
                @(posedge clk);
                #1;
                assert (arValid && ar.araddr == addr)
                    else abortRun("read address dropped or changed before its handshake");
            end
            arReady = 1'b1;
            @(posedge clk);
            #1;
            arReady = 1'b0;
            delay   = memRng[7:4] % 4;
            for (i = 0; i < delay; i++) begin
                @(posedge clk);
                #1;
            end
            assert (rReady) else abortRun("rReady low while a read response is due");
            rValid  = 1'b1;
            r.rdata = image[addr[7:0]];
            r.rresp = 2'b00;
            @(posedge clk);
            #1;
            rValid = 1'b0;
        end
    end

    // Sampled mid-cycle where values decide the next edge
    always @(negedge clk) begin
        if (!rstN) begin
            outstanding      = 0;
            lastArValid      = 1'b0;
            lastSlotFree     = 1'b1;
            lastPktValid     = 1'b0;
            lastPktReady     = 1'b0;
            lastResolveValid = 1'b0;
            lastPkt          = '0;
        end else begin
            if (lastPktValid && !lastPktReady && !lastResolveValid) begin
                assert (pktValid && pkt == lastPkt)
                    else reportMismatch("packet changed while pktReady was low");
            end
            assert (!(arValid && !lastArValid && !lastSlotFree))
                else abortRun("read address issued while the packet slot was full");
            assert (resolveResult.valid == lastResolveValid)
                else reportMismatch("resolveResult.valid not one cycle after resolve");
            // A presented address adds one read to those still in flight
            assert (outstanding + (arValid ? 1 : 0) <= 1)
                else abortRun("more than one read outstanding");
            if (arValid && arReady) outstanding++;
            if (rValid && rReady) outstanding--;
            lastArValid      = arValid;
            lastSlotFree     = !pktValid || pktReady;
            lastPktValid     = pktValid;
            lastPktReady     = pktReady;
            lastResolveValid = resolve.valid;
            lastPkt          = pkt;
        end
    end

endmodule

`default_nettype wire
